//--- common/otp_kdi_pkg.sv
// Key derivation shared types: widths, digest commands, request and response bundles
package otp_kdi_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // One digest block in and one result out
  parameter int ScrmblBlockWidth = 64;
  // One word per EDN acknowledge
  parameter int EdnDataWidth = 64;
  // Key is built from two digest results
  parameter int KeyWidth = 128;
  // Nonce holds two EDN words
  parameter int NonceWidth = 128;
  // Seed is compressed as two halves of two blocks each
  parameter int SeedWidth = 256;
  // Seed block index and entropy word index
  parameter int CntWidth = 2;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // Commands understood by the digest datapath
  typedef enum logic [1:0] {
    DigestInit,
    LoadShadow,
    Digest,
    DigestFinalize
  } scrmbl_cmd_e;

  // Netlist constant used as digest IV
  typedef enum logic [1:0] {
    FlashDataKey,
    FlashAddrKey,
    SramDataKey
  } digest_sel_e;

  // Source of the word sent to the digest
  typedef enum logic {
    SeedData,
    EntropyData
  } data_sel_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Fixed configuration of one requester
  typedef struct packed {
    logic                  ingest_entropy;
    digest_sel_e           digest_sel;
    logic                  fetch_nonce;
    // Index of the last EDN word of the nonce
    logic [1:0]            nonce_size;
    logic [SeedWidth-1:0]  seed;
  } kdi_req_bundle_t;

  // Response shared by all consumers
  typedef struct packed {
    logic [KeyWidth-1:0]   key;
    logic [NonceWidth-1:0] nonce;
    logic                  seed_valid;
  } kdi_key_rsp_t;

  // Digest datapath request, held until ready
  typedef struct packed {
    scrmbl_cmd_e                 cmd;
    digest_sel_e                 sel;
    logic [ScrmblBlockWidth-1:0] data;
    logic                        valid;
  } kdi_scrmbl_req_t;

  // Register enables and mux controls from the FSM
  typedef struct packed {
    logic                key_en;
    logic                nonce_en;
    logic                seed_valid_en;
    data_sel_e           data_sel;
    logic [CntWidth-1:0] seed_idx;
    logic [CntWidth-1:0] entropy_idx;
  } kdi_reg_ctrl_t;

endpackage

//--- source/kdi_req_arb.sv
// Round-robin key request arbiter with fixed per-requester configuration
module kdi_req_arb
  import otp_kdi_pkg::*;
#(
  parameter int NumSramSlots = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [NumSramSlots+2:0]       req_i,
  output logic [NumSramSlots+2:0]       ack_o,
  input  logic [SeedWidth-1:0]          flash_data_seed_i,
  input  logic [SeedWidth-1:0]          flash_addr_seed_i,
  input  logic [SeedWidth/2-1:0]        sram_seed_i,
  output logic                          valid_o,
  output kdi_req_bundle_t               bundle_o,
  input  logic                          ready_i
);

  // Flash data, flash addr, OTBN, then SRAM slots
  localparam int NumReq   = 3 + NumSramSlots;
  localparam int IdxWidth = $clog2(NumReq);

  kdi_req_bundle_t [NumReq-1:0] bundles;
  logic [IdxWidth-1:0]          last_q, lock_idx_q, rr_idx, idx;
  logic                         locked_q;

  ////////////////////////////////////////
  // Request configuration
  ////////////////////////////////////////

  assign bundles[0] = '{ingest_entropy: 1'b0, digest_sel: FlashDataKey, fetch_nonce: 1'b1,
                        nonce_size: 2'd1, seed: flash_data_seed_i};
  assign bundles[1] = '{ingest_entropy: 1'b0, digest_sel: FlashAddrKey, fetch_nonce: 1'b1,
                        nonce_size: 2'd0, seed: flash_addr_seed_i};
  // OTBN and SRAM share the doubled SRAM seed
  assign bundles[2] = '{ingest_entropy: 1'b1, digest_sel: SramDataKey, fetch_nonce: 1'b1,
                        nonce_size: 2'd0, seed: {sram_seed_i, sram_seed_i}};

  for (genvar k = 3; k < NumReq; k++) begin : gen_sram
    assign bundles[k] = '{ingest_entropy: 1'b1, digest_sel: SramDataKey, fetch_nonce: 1'b1,
                          nonce_size: 2'd1, seed: {sram_seed_i, sram_seed_i}};
  end

  ////////////////////////////////////////
  // Round-robin pick and lock
  ////////////////////////////////////////

  // Lowest requester above the last served one, wrapping
  always_comb begin
    int cand;
    rr_idx = last_q;
    for (int i = NumReq; i >= 1; i--) begin
      cand = (int'(last_q) + i) % NumReq;
      if (req_i[cand]) rr_idx = IdxWidth'(cand);
    end
  end

  assign idx      = locked_q ? lock_idx_q : rr_idx;
  assign valid_o  = locked_q | (|req_i);
  assign bundle_o = bundles[idx];

  always_comb begin
    ack_o      = '0;
    ack_o[idx] = ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Start as if the top index was served, so index 0 wins first
      last_q     <= IdxWidth'(NumReq - 1);
      lock_idx_q <= '0;
      locked_q   <= 1'b0;
    end else if (ready_i) begin
      last_q   <= idx;
      locked_q <= 1'b0;
    end else if (valid_o && !locked_q) begin
      lock_idx_q <= rr_idx;
      locked_q   <= 1'b1;
    end
  end

endmodule

//--- source/kdi_key_regs.sv
// Key, nonce and seed-valid registers with the digest input word mux
module kdi_key_regs
  import otp_kdi_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  kdi_reg_ctrl_t               ctrl_i,
  input  logic                        seed_valid_i,
  input  logic [SeedWidth-1:0]        seed_i,
  input  logic [ScrmblBlockWidth-1:0] scrmbl_data_i,
  input  logic [EdnDataWidth-1:0]     edn_data_i,
  output kdi_key_rsp_t                key_rsp_o,
  output logic [ScrmblBlockWidth-1:0] scrmbl_data_o
);

  localparam int KeyBlocks  = KeyWidth / ScrmblBlockWidth;
  localparam int NonceWords = NonceWidth / EdnDataWidth;

  logic [KeyBlocks-1:0][ScrmblBlockWidth-1:0] key_q;
  logic [NonceWords-1:0][EdnDataWidth-1:0]    nonce_q;
  logic                                       seed_valid_q;
  logic [ScrmblBlockWidth-1:0]                seed_block;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      // Upper seed half lands in the upper key block
      if (ctrl_i.key_en) key_q[ctrl_i.seed_idx[1]] <= scrmbl_data_i;
      if (ctrl_i.nonce_en) nonce_q[ctrl_i.entropy_idx[0]] <= edn_data_i;
      if (ctrl_i.seed_valid_en) seed_valid_q <= seed_valid_i;
    end
  end

  assign key_rsp_o.key        = key_q;
  assign key_rsp_o.nonce      = nonce_q;
  assign key_rsp_o.seed_valid = seed_valid_q;

  ////////////////////////////////////////
  // Digest data mux
  ////////////////////////////////////////

  // Invalid seeds are fed as zero blocks
  assign seed_block = seed_valid_i ?
                      seed_i[ctrl_i.seed_idx*ScrmblBlockWidth +: ScrmblBlockWidth] : '0;

  assign scrmbl_data_o = (ctrl_i.data_sel == EntropyData) ?
                         nonce_q[ctrl_i.entropy_idx[0]] : seed_block;

endmodule

//--- kdi/kdi_fsm.sv
// Key derivation control FSM sequencing digest, entropy ingest and nonce fetch
module kdi_fsm
  import otp_kdi_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        kdi_en_i,
  input  logic                        escalate_en_i,
  output logic                        fsm_err_o,
  // Arbitrated request
  input  logic                        req_valid_i,
  input  kdi_req_bundle_t             bundle_i,
  output logic                        req_ready_o,
  // EDN
  output logic                        edn_req_o,
  input  logic                        edn_ack_i,
  // Digest datapath
  output logic                        scrmbl_mtx_req_o,
  input  logic                        scrmbl_mtx_gnt_i,
  output kdi_scrmbl_req_t             scrmbl_o,
  input  logic [ScrmblBlockWidth-1:0] scrmbl_data_i,
  input  logic                        scrmbl_ready_i,
  input  logic                        scrmbl_valid_i,
  // Key register controls
  output kdi_reg_ctrl_t               reg_ctrl_o
);

  typedef enum logic [3:0] {
    ResetSt,
    IdleSt,
    ClrSt,
    LoadSt,
    FetchEntropySt,
    DigEntropySt,
    FinSt,
    WaitSt,
    FetchNonceSt,
    FinishSt,
    ErrorSt
  } state_e;

  state_e              state_d, state_q;
  logic                edn_req_d, edn_req_q;
  logic [CntWidth-1:0] seed_cnt_q, entropy_cnt_q;
  logic                seed_cnt_en, seed_cnt_clr;
  logic                entropy_cnt_en, entropy_cnt_clr;
  // Word delivered in this cycle
  logic                edn_done;

  assign edn_done  = edn_req_q & edn_ack_i;
  assign edn_req_o = edn_req_q;

  // Counters drive the register indices directly
  assign reg_ctrl_o.seed_idx    = seed_cnt_q;
  assign reg_ctrl_o.entropy_idx = entropy_cnt_q;
  assign scrmbl_o.sel           = bundle_i.digest_sel;
  assign scrmbl_o.data          = scrmbl_data_i;

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    fsm_err_o = 1'b0;
    // Keep an open EDN request alive until acknowledged
    edn_req_d = edn_req_q & ~edn_ack_i;
    seed_cnt_en     = 1'b0;
    seed_cnt_clr    = 1'b0;
    entropy_cnt_en  = 1'b0;
    entropy_cnt_clr = 1'b0;
    reg_ctrl_o.key_en        = 1'b0;
    reg_ctrl_o.nonce_en      = 1'b0;
    reg_ctrl_o.seed_valid_en = 1'b0;
    reg_ctrl_o.data_sel      = SeedData;
    scrmbl_mtx_req_o = 1'b0;
    scrmbl_o.cmd     = LoadShadow;
    scrmbl_o.valid   = 1'b0;
    req_ready_o      = 1'b0;

    unique case (state_q)
      // Wait for the enable pulse
      ResetSt: if (kdi_en_i) state_d = IdleSt;
      IdleSt: begin
        if (req_valid_i) begin
          state_d         = ClrSt;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Take the mutex and reset digest state to the IV
      ClrSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_o.valid   = 1'b1;
        scrmbl_o.cmd     = DigestInit;
        if (scrmbl_mtx_gnt_i && scrmbl_ready_i) state_d = LoadSt;
      end
      // Even block is loaded, odd block triggers the digest round
      LoadSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_o.valid   = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_o.cmd = Digest;
          if (scrmbl_ready_i) begin
            state_d = bundle_i.ingest_entropy ? FetchEntropySt : FinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Two EDN words into the nonce registers
      FetchEntropySt: begin
        scrmbl_mtx_req_o = 1'b1;
        edn_req_d        = ~(edn_done && entropy_cnt_q == 2'd1);
        if (edn_done) begin
          reg_ctrl_o.nonce_en = 1'b1;
          if (entropy_cnt_q == 2'd1) begin
            state_d         = DigEntropySt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      // Same load/digest pairing as the seed, on entropy words
      DigEntropySt: begin
        scrmbl_mtx_req_o    = 1'b1;
        scrmbl_o.valid      = 1'b1;
        reg_ctrl_o.data_sel = EntropyData;
        if (entropy_cnt_q[0]) begin
          scrmbl_o.cmd = Digest;
          if (scrmbl_ready_i) begin
            state_d         = FinSt;
            entropy_cnt_clr = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      FinSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_o.valid   = 1'b1;
        scrmbl_o.cmd     = DigestFinalize;
        if (scrmbl_ready_i) state_d = WaitSt;
      end
      // Result goes to the key half picked by seed_cnt[1]
      WaitSt: begin
        scrmbl_mtx_req_o = 1'b1;
        if (scrmbl_valid_i) begin
          reg_ctrl_o.key_en = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            // Second seed half restarts from the IV
            seed_cnt_en = 1'b1;
            state_d     = ClrSt;
          end else begin
            seed_cnt_clr             = 1'b1;
            reg_ctrl_o.seed_valid_en = 1'b1;
            state_d = bundle_i.fetch_nonce ? FetchNonceSt : FinishSt;
          end
        end
      end
      // Mutex released, nonce words up to nonce_size
      FetchNonceSt: begin
        edn_req_d = ~(edn_done && entropy_cnt_q == bundle_i.nonce_size);
        if (edn_done) begin
          reg_ctrl_o.nonce_en = 1'b1;
          if (entropy_cnt_q == bundle_i.nonce_size) begin
            state_d         = FinishSt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      FinishSt: begin
        req_ready_o = 1'b1;
        state_d     = IdleSt;
      end
      ErrorSt: fsm_err_o = 1'b1;
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything and blocks the acknowledge
    if (escalate_en_i) begin
      state_d     = ErrorSt;
      fsm_err_o   = 1'b1;
      req_ready_o = 1'b0;
    end
  end

  ////////////////////////////////////////
  // State, counters and EDN request
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ResetSt;
      edn_req_q     <= 1'b0;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      if (seed_cnt_clr) seed_cnt_q <= '0;
      else if (seed_cnt_en) seed_cnt_q <= seed_cnt_q + 1'b1;
      if (entropy_cnt_clr) entropy_cnt_q <= '0;
      else if (entropy_cnt_en) entropy_cnt_q <= entropy_cnt_q + 1'b1;
    end
  end

endmodule

//--- kdi/otp_kdi_top.sv
// Scrambling key derivation unit top: arbiter, control FSM and key registers
module otp_kdi_top
  import otp_kdi_pkg::*;
#(
  parameter int NumSramSlots = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Enable pulse and escalation
  input  logic                        kdi_en_i,
  input  logic                        escalate_en_i,
  output logic                        fsm_err_o,
  // Seeds from OTP
  input  logic                        seed_valid_i,
  input  logic [SeedWidth-1:0]        flash_data_seed_i,
  input  logic [SeedWidth-1:0]        flash_addr_seed_i,
  input  logic [SeedWidth/2-1:0]      sram_seed_i,
  // Key consumers
  input  logic [NumSramSlots+2:0]     key_req_i,
  output logic [NumSramSlots+2:0]     key_ack_o,
  output kdi_key_rsp_t                key_rsp_o,
  // EDN
  output logic                        edn_req_o,
  input  logic                        edn_ack_i,
  input  logic [EdnDataWidth-1:0]     edn_data_i,
  // Digest datapath and its mutex
  output logic                        scrmbl_mtx_req_o,
  input  logic                        scrmbl_mtx_gnt_i,
  output kdi_scrmbl_req_t             scrmbl_o,
  input  logic                        scrmbl_ready_i,
  input  logic                        scrmbl_valid_i,
  input  logic [ScrmblBlockWidth-1:0] scrmbl_data_i
);

  logic                        req_valid;
  logic                        req_ready;
  kdi_req_bundle_t             req_bundle;
  kdi_reg_ctrl_t               reg_ctrl;
  // Seed or entropy word headed for the digest
  logic [ScrmblBlockWidth-1:0] digest_word;

  kdi_req_arb #(
    .NumSramSlots(NumSramSlots)
  ) u_req_arb (
    .clk_i,
    .rst_ni,
    .req_i             (key_req_i),
    .ack_o             (key_ack_o),
    .flash_data_seed_i,
    .flash_addr_seed_i,
    .sram_seed_i,
    .valid_o           (req_valid),
    .bundle_o          (req_bundle),
    .ready_i           (req_ready)
  );

  kdi_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .escalate_en_i,
    .fsm_err_o,
    .req_valid_i     (req_valid),
    .bundle_i        (req_bundle),
    .req_ready_o     (req_ready),
    .edn_req_o,
    .edn_ack_i,
    .scrmbl_mtx_req_o,
    .scrmbl_mtx_gnt_i,
    .scrmbl_o,
    .scrmbl_data_i   (digest_word),
    .scrmbl_ready_i,
    .scrmbl_valid_i,
    .reg_ctrl_o      (reg_ctrl)
  );

  kdi_key_regs u_key_regs (
    .clk_i,
    .rst_ni,
    .ctrl_i        (reg_ctrl),
    .seed_valid_i,
    .seed_i        (req_bundle.seed),
    .scrmbl_data_i,
    .edn_data_i,
    .key_rsp_o,
    .scrmbl_data_o (digest_word)
  );

endmodule

//--- sim/tb_otp_kdi_checks.svh
// Key derivation testbench compare tasks and failure reporting
`ifndef TB_OTP_KDI_CHECKS_SVH
`define TB_OTP_KDI_CHECKS_SVH

////////////////////////////////////////
// Failure exit
////////////////////////////////////////

// Every failed check and the timeout end here
task automatic stop_on_error(input string what);
  $display("%s", what);
  $display("Regression failed");
  $fatal(1, "Stopped at the first error");
endtask

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

// Plain vectors, zero extended to one digest block
task automatic check_bits(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
  end
endtask

// Digest command as seen by the datapath
task automatic check_cmd(input string name, input scrmbl_cmd_e got, input scrmbl_cmd_e exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR t=%0t %s got %s exp %s", $time, name, got.name(), exp.name()));
  end
endtask

// Whole broadcast response: key, nonce and seed-valid
task automatic check_rsp(input string name, input kdi_key_rsp_t got, input kdi_key_rsp_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR t=%0t %s got %h exp %h", $time, name, got, exp));
  end
endtask

`endif

//--- sim/tb_otp_kdi.sv
// Key derivation unit testbench with digest and EDN models and directed tests
module tb_otp_kdi
  import otp_kdi_pkg::*;
();

  localparam int NumSramSlots = 2;
  localparam int NumReq = 3 + NumSramSlots;
  // Twelve requests of up to about 150 cycles with back-pressure, plus idle windows
  localparam int TimeoutCycles = 3000;
  localparam logic [63:0] ResultBase = 64'hC0DE_0000_0000_0000;
  localparam logic [63:0] EdnBase = 64'hED00_0000_0000_0000;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        kdi_en_i;
  logic                        escalate_en_i;
  logic                        fsm_err_o;
  logic                        seed_valid_i;
  logic [SeedWidth-1:0]        flash_data_seed_i;
  logic [SeedWidth-1:0]        flash_addr_seed_i;
  logic [SeedWidth/2-1:0]      sram_seed_i;
  logic [NumReq-1:0]           key_req_i;
  logic [NumReq-1:0]           key_ack_o;
  kdi_key_rsp_t                key_rsp_o;
  logic                        edn_req_o;
  logic                        edn_ack_i;
  logic [EdnDataWidth-1:0]     edn_data_i;
  logic                        scrmbl_mtx_req_o;
  logic                        scrmbl_mtx_gnt_i;
  kdi_scrmbl_req_t             scrmbl_o;
  logic                        scrmbl_ready_i;
  logic                        scrmbl_valid_i;
  logic [ScrmblBlockWidth-1:0] scrmbl_data_i;

  integer      seed = 3;
  int          rnd;
  logic        bp_en;
  int          cycle;
  int          res_cnt;
  int          res_delay;
  int          edn_cnt;
  int          edn_delay;
  // Every command, IV select and data word the digest model accepted
  scrmbl_cmd_e cmd_log[$];
  digest_sel_e sel_log[$];
  logic [63:0] data_log[$];

  `include "tb_otp_kdi_checks.svh"

  otp_kdi_top #(
    .NumSramSlots(NumSramSlots)
  ) DUT (
    .*
  );

  function automatic logic [63:0] edn_word(input int n);
    return EdnBase + 64'(n);
  endfunction

  function automatic logic [63:0] result_word(input int n);
    return ResultBase + 64'(n);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Rising edge monitor and timeout
  ////////////////////////////////////////

  initial begin
    cycle     = 0;
    res_cnt   = 0;
    res_delay = 0;
    edn_cnt   = 0;
    forever begin
      @(posedge clk_i);
      cycle++;
      if (cycle >= TimeoutCycles) stop_on_error("Timeout: the tests did not finish in time");
      // Result goes out in the cycle before res_delay reaches zero
      if (res_delay == 1) res_cnt++;
      if (res_delay > 0) res_delay--;
      if (scrmbl_o.valid && scrmbl_ready_i) begin
        if (!scrmbl_mtx_req_o) begin
          stop_on_error("Digest command accepted while the mutex was not requested");
        end
        cmd_log.push_back(scrmbl_o.cmd);
        sel_log.push_back(scrmbl_o.sel);
        data_log.push_back(scrmbl_o.data);
        if (scrmbl_o.cmd == DigestFinalize) res_delay = 3;
      end
      if (edn_req_o && edn_ack_i) edn_cnt++;
    end
  end

  ////////////////////////////////////////
  // Digest and EDN drivers
  ////////////////////////////////////////

  initial begin
    scrmbl_ready_i = 1'b1;
    scrmbl_valid_i = 1'b0;
    scrmbl_data_i  = '0;
    edn_ack_i      = 1'b0;
    edn_data_i     = '0;
    edn_delay      = -1;
    forever begin
      @(negedge clk_i);
      rnd = $random(seed);
      scrmbl_ready_i = bp_en ? rnd[0] : 1'b1;
      scrmbl_valid_i = (res_delay == 1);
      scrmbl_data_i  = result_word(res_cnt);
      // Acknowledge after 0 to 3 idle cycles, one word per pulse
      edn_ack_i = 1'b0;
      if (edn_req_o) begin
        if (edn_delay < 0) edn_delay = int'(rnd[5:4]);
        if (edn_delay == 0) begin
          edn_ack_i  = 1'b1;
          edn_data_i = edn_word(edn_cnt);
          edn_delay  = -1;
        end else begin
          edn_delay--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Request helpers
  ////////////////////////////////////////

  task automatic wait_ack(input int idx);
    @(negedge clk_i);
    while (key_ack_o == '0) @(negedge clk_i);
    check_bits("key_ack_o", 64'(key_ack_o), 64'(1) << idx);
  endtask

  task automatic check_log(input int pos, input scrmbl_cmd_e cmd, input logic [63:0] data);
    check_cmd("scrmbl_o.cmd", cmd_log[pos], cmd);
    check_bits("scrmbl_o.data", data_log[pos], data);
  endtask

  // One request from raise to acknowledge, then the digest log and response
  task automatic request_key(input int idx, input logic ingest, input int nonce_words,
                             input logic [SeedWidth-1:0] seed_val);
    kdi_key_rsp_t                 got;
    kdi_key_rsp_t                 exp_rsp;
    logic [1:0][EdnDataWidth-1:0] slot;
    int                           pos;
    int                           word;
    int                           res_idx;
    digest_sel_e                  exp_sel;
    slot    = key_rsp_o.nonce;
    pos     = cmd_log.size();
    word    = edn_cnt;
    res_idx = res_cnt;
    key_req_i[idx] = 1'b1;
    wait_ack(idx);
    got = key_rsp_o;
    key_req_i[idx] = 1'b0;
    @(negedge clk_i);
    check_bits("key_ack_o", 64'(key_ack_o), '0);
    check_bits("digest commands", 64'(cmd_log.size() - pos), ingest ? 64'd12 : 64'd8);
    // Flash requests have their own IV, OTBN and SRAM share one
    exp_sel = SramDataKey;
    if (idx == 0) exp_sel = FlashDataKey;
    else if (idx == 1) exp_sel = FlashAddrKey;
    for (int j = pos; j < cmd_log.size(); j++) begin
      check_bits("scrmbl_o.sel", 64'(sel_log[j]), 64'(exp_sel));
    end
    // Per half: init, two seed blocks, optional entropy pair, finalize
    for (int h = 0; h < 2; h++) begin
      check_cmd("scrmbl_o.cmd", cmd_log[pos], DigestInit);
      check_log(pos + 1, LoadShadow, seed_valid_i ? seed_val[128*h +: 64] : '0);
      check_log(pos + 2, Digest, seed_valid_i ? seed_val[128*h+64 +: 64] : '0);
      pos += 3;
      if (ingest) begin
        slot[0] = edn_word(word);
        slot[1] = edn_word(word + 1);
        check_log(pos, LoadShadow, slot[0]);
        check_log(pos + 1, Digest, slot[1]);
        pos  += 2;
        word += 2;
      end
      check_cmd("scrmbl_o.cmd", cmd_log[pos], DigestFinalize);
      pos++;
    end
    // Nonce words overwrite from slot 0 upward
    for (int k = 0; k < nonce_words; k++) begin
      slot[k] = edn_word(word);
      word++;
    end
    exp_rsp.key        = {result_word(res_idx + 1), result_word(res_idx)};
    exp_rsp.nonce      = slot;
    exp_rsp.seed_valid = seed_valid_i;
    check_rsp("key_rsp_o", got, exp_rsp);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_and_enable();
    @(negedge clk_i);
    check_bits("edn_req_o", 64'(edn_req_o), '0);
    check_bits("scrmbl_o.valid", 64'(scrmbl_o.valid), '0);
    check_bits("scrmbl_mtx_req_o", 64'(scrmbl_mtx_req_o), '0);
    check_bits("key_ack_o", 64'(key_ack_o), '0);
    check_bits("fsm_err_o", 64'(fsm_err_o), '0);
    // Held off until the enable pulse
    key_req_i[0] = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      check_bits("key_ack_o", 64'(key_ack_o), '0);
    end
    kdi_en_i = 1'b1;
    @(negedge clk_i);
    kdi_en_i = 1'b0;
  endtask

  task automatic flash_data_key();
    request_key(0, 1'b0, 2, flash_data_seed_i);
  endtask

  task automatic addr_and_otbn_keys();
    request_key(1, 1'b0, 1, flash_addr_seed_i);
    request_key(2, 1'b1, 1, {sram_seed_i, sram_seed_i});
  endtask

  task automatic sram_keys();
    request_key(3, 1'b1, 2, {sram_seed_i, sram_seed_i});
    seed_valid_i = 1'b0;
    request_key(4, 1'b1, 2, {sram_seed_i, sram_seed_i});
    seed_valid_i = 1'b1;
  endtask

  // Last served is slot 4 here, so index 0 wins first
  task automatic round_robin();
    key_req_i = '1;
    for (int i = 0; i < NumReq; i++) begin
      wait_ack(i);
      key_req_i[i] = 1'b0;
      @(negedge clk_i);
      check_bits("key_ack_o", 64'(key_ack_o), '0);
    end
  endtask

  task automatic backpressure_and_escalation();
    bp_en = 1'b1;
    request_key(0, 1'b0, 2, flash_data_seed_i);
    request_key(3, 1'b1, 2, {sram_seed_i, sram_seed_i});
    bp_en = 1'b0;
    // Escalate in the middle of the OTBN entropy fetch
    key_req_i[2] = 1'b1;
    @(negedge clk_i);
    while (!edn_req_o) @(negedge clk_i);
    escalate_en_i = 1'b1;
    @(negedge clk_i);
    escalate_en_i = 1'b0;
    // Longer than a whole OTBN request would take
    repeat (100) begin
      check_bits("fsm_err_o", 64'(fsm_err_o), 64'd1);
      check_bits("key_ack_o", 64'(key_ack_o), '0);
      @(negedge clk_i);
    end
    key_req_i[2] = 1'b0;
  endtask

  initial begin
    rst_ni            = 1'b0;
    kdi_en_i          = 1'b0;
    escalate_en_i     = 1'b0;
    seed_valid_i      = 1'b1;
    bp_en             = 1'b0;
    scrmbl_mtx_gnt_i  = 1'b1;
    key_req_i         = '0;
    flash_data_seed_i = {64'hDA7A_0003_0003_0003, 64'hDA7A_0002_0002_0002,
                         64'hDA7A_0001_0001_0001, 64'hDA7A_0000_0000_0000};
    flash_addr_seed_i = {64'hADD0_0003_0003_0003, 64'hADD0_0002_0002_0002,
                         64'hADD0_0001_0001_0001, 64'hADD0_0000_0000_0000};
    sram_seed_i       = {64'h5EED_0001_0001_0001, 64'h5EED_0000_0000_0000};
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_and_enable();
    flash_data_key();
    addr_and_otbn_keys();
    sram_keys();
    round_robin();
    backpressure_and_escalation();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- otp_kdi.f
+incdir+sim
common/otp_kdi_pkg.sv
source/kdi_req_arb.sv
source/kdi_key_regs.sv
kdi/kdi_fsm.sv
kdi/otp_kdi_top.sv
sim/tb_otp_kdi.sv

//--- run.sh
#!/bin/sh
# Compile and run the key derivation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_otp_kdi -f otp_kdi.f -o tb_otp_kdi_sim

# The simulator exits non-zero on a fatal error, the log decides
./obj_dir/tb_otp_kdi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Regression passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
